// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the UART echo testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_uart_echo -f vlog.f -o tb_uart_echo \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed."; exit 1; }

./obj_dir/tb_uart_echo > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "Simulation reported a failure."; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation ended without a result."; exit 1; }
echo "Simulation passed."
exit 0

// ==== source/case_fold_fifo.sv ====
`timescale 1ns/100ps
`include "uart_macros.svh"

module case_fold_fifo (
  input  logic            clk,
  input  logic            rst,
  input  logic            wr_valid,
  input  uart_pkg::byte_t wr_byte,
  input  logic            rd_take,
  output logic            rd_valid,
  output uart_pkg::byte_t rd_byte,
  output logic            overflow
);

  import uart_pkg::*;

  localparam int ptr_w = $clog2(`FIFO_DEPTH);

  byte_t            mem [`FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             full;
  logic             push;
  logic             pop;

  function automatic byte_t fold(input byte_t b);
    byte_t r;
    r = b;
    if (b >= 8'h61 && b <= 8'h7a) r = b - 8'h20; // 'a'..'z' to 'A'..'Z'.
    return r;
  endfunction

  assign full = (count == (ptr_w + 1)'(`FIFO_DEPTH));
  assign push = wr_valid && !full;
  assign pop  = rd_take && rd_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two.
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (wr_valid && full) overflow <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= fold(wr_byte);
  end

  assign rd_valid = (count != '0);
  assign rd_byte  = mem[rd_ptr];

  a_take_when_valid: assert property (@(posedge clk) disable iff (rst)
    rd_take |-> rd_valid);

  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= (ptr_w + 1)'(`FIFO_DEPTH));

endmodule

// ==== source/uart_echo.sv ====
`timescale 1ns/100ps

module uart_echo (
  input  logic clk,
  input  logic rst,
  input  logic rx,
  output logic tx,
  output logic frame_error,
  output logic overflow
);

  import uart_pkg::*;

  logic  rx_valid;
  byte_t rx_byte;
  logic  fifo_valid;
  byte_t fifo_byte;
  logic  fifo_take;

  uart_rx u_rx (
    .clk         (clk),
    .rst         (rst),
    .rx          (rx),
    .rx_valid    (rx_valid),
    .rx_byte     (rx_byte),
    .frame_error (frame_error)
  );

  case_fold_fifo u_fifo (
    .clk      (clk),
    .rst      (rst),
    .wr_valid (rx_valid),
    .wr_byte  (rx_byte),
    .rd_take  (fifo_take),
    .rd_valid (fifo_valid),
    .rd_byte  (fifo_byte),
    .overflow (overflow)
  );

  uart_tx u_tx (
    .clk        (clk),
    .rst        (rst),
    .byte_valid (fifo_valid),
    .byte_data  (fifo_byte),
    .byte_take  (fifo_take),
    .tx         (tx)
  );

endmodule

// ==== source/uart_macros.svh ====
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Clock rate of the core clock in Hz.
`define CLK_FREQ_HZ 75_000_000

// Line rate, picked so that one bit spans 16 clocks.
`define BAUD 4_687_500

`define CLKS_PER_BIT (`CLK_FREQ_HZ / `BAUD)

// Byte slots in the echo FIFO, power of two.
`define FIFO_DEPTH 4

// Stop bits sent on tx.
`define STOP_BITS 2

`endif

// ==== source/uart_pkg.sv ====
package uart_pkg;

  typedef logic [7:0] byte_t;

  // Receiver states.
  typedef enum logic [2:0] {
    rx_idle,
    rx_start_check,
    rx_data_wait,
    rx_data_capture,
    rx_stop_check
  } rx_state_t;

  // Transmitter states.
  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_t;

endpackage

// ==== source/uart_rx.sv ====
`timescale 1ns/100ps
`include "uart_macros.svh"

module uart_rx (
  input  logic            clk,
  input  logic            rst,
  input  logic            rx,
  output logic            rx_valid,
  output uart_pkg::byte_t rx_byte,
  output logic            frame_error
);

  import uart_pkg::*;

  localparam int cnt_w = $clog2(`CLKS_PER_BIT);

  logic             rx_meta;
  logic             rx_sync;
  rx_state_t        state, state_next;
  logic [cnt_w-1:0] cnt, cnt_next;
  logic [2:0]       bit_idx, bit_idx_next;
  byte_t            shift, shift_next;
  logic             valid_next;
  logic             stop_bad;

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta     <= 1'b1; // Line idles high.
      rx_sync     <= 1'b1;
      state       <= rx_idle;
      cnt         <= '0;
      bit_idx     <= '0;
      rx_valid    <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      rx_meta  <= rx;
      rx_sync  <= rx_meta;
      state    <= state_next;
      cnt      <= cnt_next;
      bit_idx  <= bit_idx_next;
      rx_valid <= valid_next;
      if (stop_bad) frame_error <= 1'b1; // Sticky until reset.
    end
  end

  always_ff @(posedge clk) begin
    shift <= shift_next;
  end

  always_comb begin
    state_next   = state;
    cnt_next     = cnt + 1'b1;
    bit_idx_next = bit_idx;
    shift_next   = shift;
    valid_next   = 1'b0;
    stop_bad     = 1'b0;

    case (state)
      rx_idle: begin
        cnt_next = '0;
        bit_idx_next = '0;
        if (!rx_sync) state_next = rx_start_check;
      end
      rx_start_check: begin
        // Middle of the start bit; a high line here was only a glitch.
        if (cnt == cnt_w'(`CLKS_PER_BIT / 2 - 1)) begin
          cnt_next = '0;
          state_next = rx_sync ? rx_idle : rx_data_wait;
        end
      end
      rx_data_wait: begin
        if (cnt == cnt_w'(`CLKS_PER_BIT - 2)) begin
          state_next = rx_data_capture;
        end
      end
      rx_data_capture: begin
        cnt_next = '0;
        shift_next = {rx_sync, shift[7:1]}; // LSB arrives first.
        bit_idx_next = bit_idx + 1'b1;
        state_next = (bit_idx == 3'd7) ? rx_stop_check : rx_data_wait;
      end
      rx_stop_check: begin
        if (cnt == cnt_w'(`CLKS_PER_BIT - 1)) begin
          cnt_next = '0;
          valid_next = rx_sync;
          stop_bad = !rx_sync;
          state_next = rx_idle;
        end
      end
      default: state_next = rx_idle;
    endcase
  end

  assign rx_byte = shift;

  // A byte takes a whole frame, so strobes never come back to back.
  a_valid_single: assert property (@(posedge clk) disable iff (rst)
    rx_valid |=> !rx_valid);

  a_valid_not_error: assert property (@(posedge clk) disable iff (rst)
    !(rx_valid && $rose(frame_error)));

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/100ps
`include "uart_macros.svh"

module uart_tx (
  input  logic            clk,
  input  logic            rst,
  input  logic            byte_valid,
  input  uart_pkg::byte_t byte_data,
  output logic            byte_take,
  output logic            tx
);

  import uart_pkg::*;

  localparam int cnt_w = $clog2(`STOP_BITS * `CLKS_PER_BIT);

  tx_state_t        state;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  byte_t            shift;
  logic             bit_end;

  assign byte_take = (state == tx_idle) && byte_valid;
  assign bit_end   = (cnt == cnt_w'(`CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= tx_idle;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
      case (state)
        tx_idle: begin
          cnt <= '0;
          bit_idx <= '0;
          if (byte_take) begin
            tx <= 1'b0; // Start bit.
            state <= tx_start;
          end
        end
        tx_start: if (bit_end) begin
          cnt <= '0;
          tx <= shift[0];
          state <= tx_data;
        end
        tx_data: if (bit_end) begin
          cnt <= '0;
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) begin
            tx <= 1'b1;
            state <= tx_stop;
          end else begin
            tx <= shift[1];
          end
        end
        tx_stop: begin
          // All stop bits are counted as one stretch.
          if (cnt == cnt_w'(`STOP_BITS * `CLKS_PER_BIT - 1)) state <= tx_idle;
        end
        default: state <= tx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (byte_take) begin
      shift <= byte_data;
    end else if (state == tx_data && bit_end) begin
      shift <= shift >> 1;
    end
  end

  a_idle_high: assert property (@(posedge clk) disable iff (rst)
    (state == tx_idle) |-> tx);

endmodule

// ==== testbench/tb_uart_echo.sv ====
`timescale 1ns/100ps
`include "uart_macros.svh"

module tb_uart_echo;

  import uart_pkg::*;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        rx  = 1'b1;
  logic        tx;
  logic        frame_error;
  logic        overflow;

  logic [15:0] lfsr = 16'd12;
  byte_t       exp_q[$];  // Folded bytes still due on tx.
  logic        subseq_mode = 1'b0;
  logic        mon_busy = 1'b0;
  logic        rx_seen;
  logic        echo_pulse = 1'b0;
  logic        echo_known = 1'b0;
  byte_t       echo_got = '0;
  byte_t       echo_exp = '0;
  logic [1:0]  echo_stops = 2'b11;
  logic        ferr_allowed = 1'b0;
  logic        ferr_expected = 1'b0;
  logic        ovf_allowed = 1'b0;
  logic        ovf_expected = 1'b0;

  uart_echo DUT (
    .clk         (clk),
    .rst         (rst),
    .rx          (rx),
    .tx          (tx),
    .frame_error (frame_error),
    .overflow    (overflow)
  );

  always #20 clk = ~clk; // 40 ns period.

  always @(posedge clk) begin
    if (rst) rx_seen <= 1'b0;
    else if (DUT.u_rx.rx_valid) rx_seen <= 1'b1;
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic rand_byte(output byte_t b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  // Lower-case letters lose bit 5, everything else passes.
  function automatic byte_t upper_ascii(input byte_t c);
    if (c inside {[8'h61:8'h7a]}) return c & 8'hdf;
    return c;
  endfunction

  task automatic hold_bit(input logic v);
    rx <= v;
    repeat (`CLKS_PER_BIT) @(posedge clk);
  endtask

  task automatic send_frame(input byte_t d, input logic stop, input int gap_bits);
    hold_bit(1'b0);
    for (int i = 0; i < 8; i++) hold_bit(d[i]); // LSB first.
    hold_bit(stop);
    repeat (gap_bits) hold_bit(1'b1);
  endtask

  task automatic send_paced(input byte_t d);
    exp_q.push_back(upper_ascii(d));
    send_frame(d, 1'b1, 4);
  endtask

  task automatic send_glitch(input int len);
    rx <= 1'b0;
    repeat (len) @(posedge clk);
    rx <= 1'b1;
  endtask

  task automatic wait_echoes(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 || mon_busy) begin
      @(posedge clk);
      n++;
      if (n > limit) begin
        $display("Timeout: %0d bytes never came back on tx.", exp_q.size());
        abort_run();
      end
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic wait_tx_quiet(input int limit);
    int n;
    n = 0;
    while (DUT.u_fifo.rd_valid || DUT.u_tx.state != tx_idle || mon_busy) begin
      @(posedge clk);
      n++;
      if (n > limit) begin
        $display("Timeout: transmitter still busy after %0d cycles.", limit);
        abort_run();
      end
    end
    repeat (4) @(posedge clk);
  endtask

  // Samples tx at mid-bit, starting from the falling edge of the start bit.
  initial begin : tx_monitor
    byte_t got;
    byte_t exp_b;
    logic  stop1;
    logic  stop2;
    forever begin
      @(posedge clk);
      echo_pulse <= 1'b0;
      if (!rst && !tx) begin
        mon_busy = 1'b1;
        repeat (`CLKS_PER_BIT / 2 - 1) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (`CLKS_PER_BIT) @(posedge clk);
          got[i] = tx;
        end
        repeat (`CLKS_PER_BIT) @(posedge clk);
        stop1 = tx;
        repeat (`CLKS_PER_BIT) @(posedge clk);
        stop2 = tx;
        if (subseq_mode) begin
          while (exp_q.size() > 0 && exp_q[0] != got) void'(exp_q.pop_front());
        end
        if (exp_q.size() > 0) begin
          exp_b = exp_q.pop_front();
          echo_exp   <= exp_b;
          echo_known <= 1'b1;
        end else begin
          echo_known <= 1'b0;
        end
        echo_got   <= got;
        echo_stops <= {stop2, stop1};
        echo_pulse <= 1'b1;
        mon_busy = 1'b0;
      end
    end
  end

  a_reset_values: assert property (@(posedge clk) rst |=> tx && !frame_error && !overflow)
    else begin
      $display("Outputs were not idle right after reset.");
      abort_run();
    end

  a_tx_idle: assert property (@(posedge clk) disable iff (rst) !rx_seen |-> tx)
    else begin
      $display("tx left idle before any byte was received.");
      abort_run();
    end

  a_echo_byte: assert property (@(posedge clk) disable iff (rst)
    echo_pulse && echo_known |-> echo_got == echo_exp)
    else begin
      $display("MISMATCH tx byte: expected 8'h%02h, actual 8'h%02h", echo_exp, echo_got);
      abort_run();
    end

  a_echo_known: assert property (@(posedge clk) disable iff (rst) echo_pulse |-> echo_known)
    else begin
      $display("A byte 8'h%02h came back on tx that was never expected.", echo_got);
      abort_run();
    end

  a_echo_stops: assert property (@(posedge clk) disable iff (rst)
    echo_pulse |-> echo_stops == 2'b11)
    else begin
      $display("The two stop bits on tx were not both high.");
      abort_run();
    end

  a_ferr_low: assert property (@(posedge clk) disable iff (rst) !ferr_allowed |-> !frame_error)
    else begin
      $display("frame_error rose without a bad stop bit.");
      abort_run();
    end

  a_ferr_held: assert property (@(posedge clk) disable iff (rst) ferr_expected |-> frame_error)
    else begin
      $display("frame_error is low after a bad stop bit.");
      abort_run();
    end

  a_ovf_low: assert property (@(posedge clk) disable iff (rst) !ovf_allowed |-> !overflow)
    else begin
      $display("overflow rose while input was paced.");
      abort_run();
    end

  a_ovf_held: assert property (@(posedge clk) disable iff (rst)
    (ovf_expected || overflow) |=> overflow)
    else begin
      $display("overflow is low after the burst or dropped before reset.");
      abort_run();
    end

  initial begin : stimulus
    byte_t b;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (100) @(posedge clk); // No input yet, tx must stay high.

    for (int k = 0; k < 40; k++) begin
      rand_byte(b);
      send_paced(b);
    end
    wait_echoes(2000);

    send_glitch(`CLKS_PER_BIT / 2 - 3);
    repeat (400) @(posedge clk);

    ferr_allowed <= 1'b1;
    send_frame(8'h6b, 1'b0, 4); // Low stop bit.
    ferr_expected <= 1'b1;
    send_paced(8'h61); // Edges of the fold range.
    send_paced(8'h7a);
    send_paced(8'h60);
    send_paced(8'h7b);
    wait_echoes(2000);

    ovf_allowed <= 1'b1;
    subseq_mode = 1'b1;
    for (int k = 0; k < 60; k++) begin
      rand_byte(b);
      exp_q.push_back(upper_ascii(b));
      send_frame(b, 1'b1, 0); // Back to back, one stop bit.
    end
    ovf_expected <= 1'b1;
    wait_tx_quiet(3000);

    rst <= 1'b1;
    ferr_allowed  <= 1'b0;
    ferr_expected <= 1'b0;
    ovf_allowed   <= 1'b0;
    ovf_expected  <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    subseq_mode = 1'b0;
    exp_q.delete();
    repeat (20) @(posedge clk);

    send_paced(8'h71);
    wait_echoes(1000);
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/uart_pkg.sv
source/uart_rx.sv
source/case_fold_fifo.sv
source/uart_tx.sv
source/uart_echo.sv
testbench/tb_uart_echo.sv
